// ==== vlog.f ====
hdl/axi_mem_pkg.sv
hdl/rd_slot_fifo.sv
hdl/axi_buffered_read.sv
hdl/axi_sram_sink.sv
hdl/axi_mem_subsys.sv
verification/tb_clock_gen.sv
verification/tb_axi_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP = tb_axi_mem_subsys
FLIST = vlog.f
LOG = sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_axi_mem_subsys.sv ====
// AXI memory subsystem testbench

`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem_subsys;
    import axi_mem_pkg::*;

    localparam int NUM_READ_ENTRIES = 32;
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW = $clog2(MEM_WORDS);
    // Reserved slots above this level must hold off new reads
    localparam int SLOT_LIMIT = NUM_READ_ENTRIES - 16;
    localparam int N_FILL = MEM_WORDS / 16;
    localparam int N_WRITES = 96;
    localparam int N_READS = 200;
    localparam int N_STALL_READS = 40;
    localparam int STALL_CYCLES = 200;
    localparam int N_BURSTS = N_FILL + N_WRITES + N_READS + N_STALL_READS;
    // Up to 16 beats per burst at 6 cycles each, plus the long read stall
    localparam int MAX_CYCLES = N_BURSTS * 16 * 6 + STALL_CYCLES * 8;

    logic     clk;
    logic     rst_n;
    logic     ar_valid;
    logic     ar_ready;
    ar_chan_t ar;
    logic     r_valid;
    logic     r_ready;
    r_chan_t  r;
    logic     aw_valid;
    logic     aw_ready;
    aw_chan_t aw;
    logic     w_valid;
    logic     w_ready;
    w_chan_t  w;
    logic     b_valid;
    logic     b_ready;
    b_chan_t  b;

    logic [31:0]       seed;
    // Mirror of the sink contents, updated as W beats are accepted
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    r_chan_t           exp_q [$];
    // Sum of len+1 over accepted reads minus beats received
    int                outstanding;
    int                cycle_cnt = 0;

    tb_clock_gen #(
        .PERIOD_NS(4)
    ) u_clk_gen (
        .clk(clk)
    );

    axi_mem_subsys #(
        .NUM_READ_ENTRIES(NUM_READ_ENTRIES),
        .MEM_WORDS       (MEM_WORDS)
    ) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar      (ar),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r       (r),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .aw      (aw),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .w       (w),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .b       (b)
    );

    // LCG step
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Value in 0 to n-1, upper bits are the better ones
    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] v;
        v = next_random();
        return (v >> 8) % n;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    // Hard stop if the DUT hangs
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Timed out");
        end
    end

    // Entered and left on a falling edge
    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                               input logic [LEN_W-1:0] len);
        logic [MEM_AW-1:0] idx;
        logic [DATA_W-1:0] data;
        int                i;
        aw_valid = 1'b1;
        aw.addr = addr;
        aw.id = id;
        aw.len = len;
        #1;
        while (!aw_ready)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        aw_valid = 1'b0;
        for (i = 0; i <= int'(len); i++)
        begin
            data = next_random();
            idx = MEM_AW'((int'(addr) + i) % MEM_WORDS);
            w_valid = 1'b1;
            w.data = data;
            w.last = (i == int'(len));
            #1;
            while (!w_ready)
            begin
                @(negedge clk);
                #1;
            end
            model_mem[idx] = data;
            @(negedge clk);
        end
        w_valid = 1'b0;
        // Response side may lag a little
        repeat (rand_below(3)) @(negedge clk);
        b_ready = 1'b1;
        #1;
        while (!b_valid)
        begin
            @(negedge clk);
            #1;
        end
        check_value(32'(b.id), 32'(id), "write response id");
        @(negedge clk);
        b_ready = 1'b0;
        #1;
        check_value(32'(b_valid), 32'd0, "second write response for one burst");
        @(negedge clk);
    endtask

    // Issues reads and drains beats in one loop so random draws stay in a fixed order
    task automatic run_reads(input int n_reads, input int unsigned ready_pct,
                             input int stall_cycles);
        r_chan_t           exp_beat;
        logic [MEM_AW-1:0] idx;
        int                i;
        int                issued;
        int                cycles;
        bit                ar_done;
        bit                was_blocked;
        bit                reopened;
        issued = 0;
        cycles = 0;
        ar_done = 1'b0;
        was_blocked = 1'b0;
        reopened = 1'b0;
        while (issued < n_reads || exp_q.size() != 0)
        begin
            if (ar_done)
            begin
                ar_valid = 1'b0;
                ar_done = 1'b0;
            end
            if (!ar_valid && issued < n_reads && rand_below(4) != 0)
            begin
                ar_valid = 1'b1;
                ar.addr = ADDR_W'(next_random());
                ar.id = ID_W'(rand_below(16));
                ar.len = LEN_W'(rand_below(16));
            end
            if (cycles < stall_cycles)
                r_ready = 1'b0;
            else
                r_ready = (rand_below(100) < ready_pct);
            #1;
            // Count is that of the last edge, same as the DUT counter
            check_value(32'(ar_ready && outstanding > SLOT_LIMIT), 32'd0,
                        "ar_ready high with reserved slots over the limit");
            if (outstanding > SLOT_LIMIT)
                was_blocked = 1'b1;
            if (was_blocked && cycles >= stall_cycles && ar_ready)
                reopened = 1'b1;
            if (r_valid && r_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Read beat arrived at %0t ns with no read outstanding", $time);
                    $display("Simulation failed");
                    $fatal(1, "Unexpected read beat");
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    check_value(r.data, exp_beat.data, "read data");
                    check_value(32'(r.id), 32'(exp_beat.id), "read id");
                    check_value(32'(r.last), 32'(exp_beat.last), "read last flag");
                    outstanding--;
                end
            end
            if (ar_valid && ar_ready)
            begin
                // Expected beats walk up from the start address, wrapping in the RAM
                for (i = 0; i <= int'(ar.len); i++)
                begin
                    idx = MEM_AW'((int'(ar.addr) + i) % MEM_WORDS);
                    exp_beat.data = model_mem[idx];
                    exp_beat.id = ar.id;
                    exp_beat.last = (i == int'(ar.len));
                    exp_q.push_back(exp_beat);
                end
                outstanding += int'(ar.len) + 1;
                issued++;
                ar_done = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        ar_valid = 1'b0;
        r_ready = 1'b0;
        if (stall_cycles > 0)
        begin
            check_value(32'(was_blocked), 32'd1, "reserved slots never reached the limit");
            check_value(32'(reopened), 32'd1, "ar_ready did not return after draining");
        end
    endtask

    initial
    begin
        int i;
        seed = 32'h0dedc961;
        outstanding = 0;
        rst_n = 1'b0;
        ar_valid = 1'b0;
        ar = '0;
        r_ready = 1'b0;
        aw_valid = 1'b0;
        aw = '0;
        w_valid = 1'b0;
        w = '0;
        b_ready = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value(32'(r_valid), 32'd0, "r_valid after reset");
        check_value(32'(b_valid), 32'd0, "b_valid after reset");
        @(negedge clk);
        // Fill the whole RAM so that every read has a known value
        for (i = 0; i < N_FILL; i++)
        begin
            write_burst(ADDR_W'(i * 16), ID_W'(rand_below(16)), LEN_W'(15));
        end
        for (i = 0; i < N_WRITES; i++)
        begin
            write_burst(ADDR_W'(next_random()), ID_W'(rand_below(16)),
                        LEN_W'(rand_below(16)));
        end
        run_reads(N_READS / 2, 100, 0);
        run_reads(N_READS / 2, 50, 0);
        // Requester stalls while reads keep arriving
        run_reads(N_STALL_READS, 70, STALL_CYCLES);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock source

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    // Free running, starts low so the first rising edge lands at half a period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_mem_subsys.sv ====
// AXI memory port subsystem

`timescale 1ns/1ns
`default_nettype none

module axi_mem_subsys #(
    parameter int NUM_READ_ENTRIES = 512,
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_mem_pkg::ar_chan_t ar,
    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_mem_pkg::r_chan_t  r,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_mem_pkg::aw_chan_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  axi_mem_pkg::w_chan_t  w,
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_mem_pkg::b_chan_t  b
);
    import axi_mem_pkg::*;

    // Memory side channels between the read buffer and the sink
    logic     mem_ar_valid;
    logic     mem_ar_ready;
    ar_chan_t mem_ar;
    logic     mem_r_valid;
    logic     mem_r_ready;
    r_chan_t  mem_r;
    logic     mem_aw_valid;
    logic     mem_aw_ready;
    aw_chan_t mem_aw;
    logic     mem_w_valid;
    logic     mem_w_ready;
    w_chan_t  mem_w;
    logic     mem_b_valid;
    logic     mem_b_ready;
    b_chan_t  mem_b;

    axi_buffered_read #(
        .NUM_READ_ENTRIES(NUM_READ_ENTRIES)
    ) u_buffered_read (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w           (w),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b           (b),
        .mem_ar_valid(mem_ar_valid),
        .mem_ar_ready(mem_ar_ready),
        .mem_ar      (mem_ar),
        .mem_r_valid (mem_r_valid),
        .mem_r_ready (mem_r_ready),
        .mem_r       (mem_r),
        .mem_aw_valid(mem_aw_valid),
        .mem_aw_ready(mem_aw_ready),
        .mem_aw      (mem_aw),
        .mem_w_valid (mem_w_valid),
        .mem_w_ready (mem_w_ready),
        .mem_w       (mem_w),
        .mem_b_valid (mem_b_valid),
        .mem_b_ready (mem_b_ready),
        .mem_b       (mem_b)
    );

    // Block RAM behind the buffered read stage
    axi_sram_sink #(
        .MEM_WORDS(MEM_WORDS)
    ) u_sram_sink (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_valid(mem_ar_valid),
        .ar_ready(mem_ar_ready),
        .ar      (mem_ar),
        .r_valid (mem_r_valid),
        .r_ready (mem_r_ready),
        .r       (mem_r),
        .aw_valid(mem_aw_valid),
        .aw_ready(mem_aw_ready),
        .aw      (mem_aw),
        .w_valid (mem_w_valid),
        .w_ready (mem_w_ready),
        .w       (mem_w),
        .b_valid (mem_b_valid),
        .b_ready (mem_b_ready),
        .b       (mem_b)
    );

endmodule

`default_nettype wire

// ==== hdl/axi_sram_sink.sv ====
// AXI block RAM sink

`timescale 1ns/1ns
`default_nettype none

module axi_sram_sink #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_mem_pkg::ar_chan_t ar,
    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_mem_pkg::r_chan_t  r,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_mem_pkg::aw_chan_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  axi_mem_pkg::w_chan_t  w,
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_mem_pkg::b_chan_t  b
);
    import axi_mem_pkg::*;

    // Word index, power of two depth so increments wrap modulo MEM_WORDS
    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_STREAM} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    logic [DATA_W-1:0] ram [MEM_WORDS];

    rd_state_t         rd_state;
    rd_state_t         rd_state_nxt;
    logic [IDX_W-1:0]  rd_addr;
    logic [ID_W-1:0]   rd_id;
    logic [LEN_W-1:0]  rd_len;
    logic [LEN_W-1:0]  rd_beat;
    logic [DATA_W-1:0] rd_data;
    logic              rd_fire;
    logic              rd_last;
    logic              rd_load;
    logic [IDX_W-1:0]  rd_fetch_addr;

    wr_state_t         wr_state;
    wr_state_t         wr_state_nxt;
    logic [IDX_W-1:0]  wr_addr;
    logic [ID_W-1:0]   wr_id;
    logic [LEN_W-1:0]  wr_len;
    logic [LEN_W-1:0]  wr_beat;
    logic              wr_fire;

    // Read side
    assign rd_fire = r_valid && r_ready;
    assign rd_last = (rd_beat == rd_len);
    assign r_valid = (rd_state == RD_STREAM);
    assign r.data = rd_data;
    assign r.id = rd_id;
    assign r.last = rd_last;

    always_comb
    begin
        rd_state_nxt = rd_state;
        case (rd_state)
            RD_IDLE:   if (ar_valid && ar_ready) rd_state_nxt = RD_FETCH;
            RD_FETCH:  rd_state_nxt = RD_STREAM;
            RD_STREAM: if (rd_fire && rd_last) rd_state_nxt = RD_IDLE;
            default:   rd_state_nxt = RD_IDLE;
        endcase
    end

    // RAM read enable, first word in fetch, next word on each accepted beat
    assign rd_load = (rd_state == RD_FETCH) || (rd_fire && !rd_last);
    assign rd_fetch_addr = (rd_state == RD_FETCH) ? rd_addr : rd_addr + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_state <= RD_IDLE;
            ar_ready <= 1'b0;
        end
        else
        begin
            rd_state <= rd_state_nxt;
            // Ready again the cycle after the last beat goes out
            ar_ready <= (rd_state_nxt == RD_IDLE);
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_valid && ar_ready)
        begin
            rd_addr <= ar.addr[IDX_W-1:0];
            rd_id <= ar.id;
            rd_len <= ar.len;
            rd_beat <= '0;
        end
        else if (rd_fire && !rd_last)
        begin
            rd_addr <= rd_addr + 1'b1;
            rd_beat <= rd_beat + 1'b1;
        end
        if (rd_load)
        begin
            rd_data <= ram[rd_fetch_addr];
        end
        if (wr_fire)
        begin
            ram[wr_addr] <= w.data;
        end
    end

    // Write side
    assign wr_fire = w_valid && w_ready;
    assign w_ready = (wr_state == WR_DATA);
    assign b_valid = (wr_state == WR_RESP);
    assign b.id = wr_id;

    always_comb
    begin
        wr_state_nxt = wr_state;
        case (wr_state)
            WR_IDLE: if (aw_valid && aw_ready) wr_state_nxt = WR_DATA;
            WR_DATA: if (wr_fire && wr_beat == wr_len) wr_state_nxt = WR_RESP;
            WR_RESP: if (b_ready) wr_state_nxt = WR_IDLE;
            default: wr_state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_state <= WR_IDLE;
            aw_ready <= 1'b0;
        end
        else
        begin
            wr_state <= wr_state_nxt;
            aw_ready <= (wr_state_nxt == WR_IDLE);
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_valid && aw_ready)
        begin
            wr_addr <= aw.addr[IDX_W-1:0];
            wr_id <= aw.id;
            wr_len <= aw.len;
            wr_beat <= '0;
        end
        else if (wr_fire)
        begin
            wr_addr <= wr_addr + 1'b1;
            wr_beat <= wr_beat + 1'b1;
        end
    end

    // Requester's last flag agrees with the AW burst length
    w_last_a: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire |-> (w.last == (wr_beat == wr_len)));

endmodule

`default_nettype wire

// ==== hdl/axi_buffered_read.sv ====
// Buffered AXI read stage

`timescale 1ns/1ns
`default_nettype none

module axi_buffered_read #(
    parameter int NUM_READ_ENTRIES = 512
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Requester side
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_mem_pkg::ar_chan_t ar,
    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_mem_pkg::r_chan_t  r,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_mem_pkg::aw_chan_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  axi_mem_pkg::w_chan_t  w,
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_mem_pkg::b_chan_t  b,
    // Memory side
    output logic                  mem_ar_valid,
    input  logic                  mem_ar_ready,
    output axi_mem_pkg::ar_chan_t mem_ar,
    input  logic                  mem_r_valid,
    output logic                  mem_r_ready,
    input  axi_mem_pkg::r_chan_t  mem_r,
    output logic                  mem_aw_valid,
    input  logic                  mem_aw_ready,
    output axi_mem_pkg::aw_chan_t mem_aw,
    output logic                  mem_w_valid,
    input  logic                  mem_w_ready,
    output axi_mem_pkg::w_chan_t  mem_w,
    input  logic                  mem_b_valid,
    output logic                  mem_b_ready,
    input  axi_mem_pkg::b_chan_t  mem_b
);
    import axi_mem_pkg::*;

    logic       almost_full;
    logic       ar_fire;
    alloc_cnt_t alloc_cnt;

    // Hold off new reads in both directions until slots free up
    assign ar_ready = mem_ar_ready && !almost_full;
    assign mem_ar_valid = ar_valid && !almost_full;
    assign mem_ar = ar;
    assign ar_fire = ar_valid && ar_ready;

    // AXI len is zero based while the slot count is one based
    assign alloc_cnt = {1'b0, ar.len} + alloc_cnt_t'(1);

    rd_slot_fifo #(
        .N_ENTRIES(NUM_READ_ENTRIES)
    ) u_rd_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (ar_fire),
        .alloc_cnt  (alloc_cnt),
        .almost_full(almost_full),
        .enq_en     (mem_r_valid && mem_r_ready),
        .enq_data   (mem_r),
        .not_full   (mem_r_ready),
        .first      (r),
        .deq_en     (r_valid && r_ready),
        .not_empty  (r_valid)
    );

    // Write channels pass straight across
    assign mem_aw_valid = aw_valid;
    assign aw_ready = mem_aw_ready;
    assign mem_aw = aw;
    assign mem_w_valid = w_valid;
    assign w_ready = mem_w_ready;
    assign mem_w = w;
    assign b_valid = mem_b_valid;
    assign mem_b_ready = b_ready;
    assign b = mem_b;

    // Every beat in flight already holds a slot so the sink never waits on read data
    mem_r_not_stalled_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_r_valid |-> mem_r_ready);

endmodule

`default_nettype wire

// ==== hdl/rd_slot_fifo.sv ====
// Read response slot FIFO

`timescale 1ns/1ns
`default_nettype none

module rd_slot_fifo #(
    parameter int N_ENTRIES = 512
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Slot reservation at request time
    input  logic                  alloc_en,
    input  axi_mem_pkg::alloc_cnt_t alloc_cnt,
    output logic                  almost_full,
    // Incoming beats from the memory side
    input  logic                  enq_en,
    input  axi_mem_pkg::r_chan_t  enq_data,
    output logic                  not_full,
    // Outgoing beats to the requester
    output axi_mem_pkg::r_chan_t  first,
    input  logic                  deq_en,
    output logic                  not_empty
);
    import axi_mem_pkg::*;

    // Largest single reservation is one full burst
    localparam int MAX_ALLOC = 2 ** LEN_W;
    localparam int PTR_W = $clog2(N_ENTRIES);
    // Counter needs one more bit to hold N_ENTRIES itself
    localparam int RES_W = PTR_W + 1;
    localparam logic [RES_W-1:0] AF_LEVEL = RES_W'(N_ENTRIES - MAX_ALLOC);

    // Depth must cover a whole burst and wrap cleanly on the pointers
    if (N_ENTRIES < MAX_ALLOC || (N_ENTRIES & (N_ENTRIES - 1)) != 0)
    begin : g_bad_depth
        $error("rd_slot_fifo needs a power of two depth of at least 16");
    end

    // Beat storage
    r_chan_t entries [N_ENTRIES];

    // Pointers carry a wrap bit to tell full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;

    // Slots reserved by accepted requests and not yet dequeued
    logic [RES_W-1:0] res_cnt;
    logic [RES_W-1:0] res_add;
    logic [RES_W-1:0] res_sub;

    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign not_full = !full;
    assign not_empty = (wr_ptr != rd_ptr);

    // Head of queue is read combinationally for a same-cycle dequeue
    assign first = entries[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            entries[wr_ptr[PTR_W-1:0]] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Reservation grows by a burst and shrinks by one beat per dequeue
    assign res_add = alloc_en ? RES_W'(alloc_cnt) : '0;
    assign res_sub = {{(RES_W-1){1'b0}}, deq_en};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            res_cnt <= '0;
        end
        else
        begin
            res_cnt <= res_cnt + res_add - res_sub;
        end
    end

    // Room for one more maximum burst only at or below this level
    assign almost_full = (res_cnt > AF_LEVEL);

    // Reservation should make overflow impossible
    enq_not_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        enq_en |-> not_full);

    res_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        res_cnt <= RES_W'(N_ENTRIES));

    deq_not_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
        deq_en |-> not_empty);

endmodule

`default_nettype wire

// ==== hdl/axi_mem_pkg.sv ====
// AXI memory port types

`default_nettype none

package axi_mem_pkg;

    // Word address, transaction id and zero-based burst length widths
    localparam int ADDR_W = 16;
    localparam int ID_W = 4;
    localparam int LEN_W = 4;

    // Data bus width, one word per beat
    localparam int DATA_W = 32;

    // Read address channel payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [LEN_W-1:0]  len;
    } ar_chan_t;

    // Write address channel payload, same layout as AR
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [LEN_W-1:0]  len;
    } aw_chan_t;

    // Write data beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } w_chan_t;

    // Read data beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        logic              last;
    } r_chan_t;

    // Write response, id only since errors are never reported
    typedef struct packed {
        logic [ID_W-1:0] id;
    } b_chan_t;

    // One-based beat count
    // Extra bit so that a full 16 beat burst fits
    typedef logic [LEN_W:0] alloc_cnt_t;

endpackage

`default_nettype wire
